/* Bender.yml */
package:
  name: trap_unit

sources:
  # Package first, then the blocks, then the top level
  - hdl/trap_pkg.sv
  - hdl/trap_wb_stage.sv
  - hdl/trap_csr_regs.sv
  - hdl/trap_ctrl.sv
  - hdl/trap_sva.sv
  - hdl/trap_unit.sv

  # Testbench with its included model header
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_trap_unit.sv

/* hdl/trap_csr_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module trap_csr_regs (
  input  wire logic                              clk,
  input  wire logic                              rst_ni,
  input  wire logic                              csr_we_i,
  input  wire trap_pkg::csr_addr_e               csr_waddr_i,
  input  wire logic [trap_pkg::XLEN-1:0]         csr_wdata_i,
  input  wire trap_pkg::csr_addr_e               csr_raddr_i,
  input  wire trap_pkg::trap_req_t               trap_req_i,
  input  wire logic                              mret_exec_i,
  output logic [trap_pkg::XLEN-1:0]              csr_rdata_o,
  output logic [trap_pkg::NUM_IRQ-1:0]           mie_o,
  output logic                                   mstatus_mie_o,
  output logic [trap_pkg::XLEN-1:0]              mepc_o
);

  logic                          mstatus_mie_q;
  logic                          mstatus_mpie_q;
  logic [trap_pkg::NUM_IRQ-1:0]  mie_q;
  logic [trap_pkg::XLEN-1:2]     mepc_q;
  logic                          mcause_irq_q;
  logic [4:0]                    mcause_code_q;
  logic [trap_pkg::XLEN-1:0]     mstatus_wdata;
  logic                          wr_mstatus;
  logic                          wr_mie;
  logic                          wr_mepc;
  logic                          wr_mcause;

  assign wr_mstatus = csr_we_i && (csr_waddr_i == trap_pkg::CSR_MSTATUS);
  assign wr_mie     = csr_we_i && (csr_waddr_i == trap_pkg::CSR_MIE);
  assign wr_mepc    = csr_we_i && (csr_waddr_i == trap_pkg::CSR_MEPC);
  assign wr_mcause  = csr_we_i && (csr_waddr_i == trap_pkg::CSR_MCAUSE);

  // Bits outside MIE and MPIE do not exist and are dropped on write
  assign mstatus_wdata = csr_wdata_i & trap_pkg::CSR_WRITABLE_MASK;

  //////////////////////////////////////////////////////////////////////
  // Register updates, hardware events before software writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (trap_req_i.take) begin
      // Stack the enable and block further interrupts in the handler
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mret_exec_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (wr_mstatus) begin
      mstatus_mie_q  <= mstatus_wdata[trap_pkg::MSTATUS_MIE_BIT];
      mstatus_mpie_q <= mstatus_wdata[trap_pkg::MSTATUS_MPIE_BIT];
    end
  end

  // mie has no hardware writer so software always gets through
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (wr_mie) begin
      mie_q <= csr_wdata_i[trap_pkg::NUM_IRQ-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mepc_q        <= '0;
      mcause_irq_q  <= 1'b0;
      mcause_code_q <= '0;
    end else begin
      // Low two bits of mepc are hardwired to zero
      if (trap_req_i.take) begin
        mepc_q <= trap_req_i.epc[trap_pkg::XLEN-1:2];
      end else if (wr_mepc) begin
        mepc_q <= csr_wdata_i[trap_pkg::XLEN-1:2];
      end
      if (trap_req_i.take) begin
        mcause_irq_q  <= trap_req_i.is_irq;
        mcause_code_q <= trap_req_i.cause;
      end else if (wr_mcause) begin
        mcause_irq_q  <= csr_wdata_i[trap_pkg::XLEN-1];
        mcause_code_q <= csr_wdata_i[4:0];
      end
    end
  end

  // Read mux, unmapped addresses return zero
  always_comb begin
    csr_rdata_o = '0;
    case (csr_raddr_i)
      trap_pkg::CSR_MSTATUS: begin
        csr_rdata_o[trap_pkg::MSTATUS_MIE_BIT]  = mstatus_mie_q;
        csr_rdata_o[trap_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      trap_pkg::CSR_MIE:    csr_rdata_o[trap_pkg::NUM_IRQ-1:0] = mie_q;
      trap_pkg::CSR_MEPC:   csr_rdata_o = {mepc_q, 2'b00};
      trap_pkg::CSR_MCAUSE: begin
        csr_rdata_o[trap_pkg::XLEN-1] = mcause_irq_q;
        csr_rdata_o[4:0]              = mcause_code_q;
      end
      default: csr_rdata_o = '0;
    endcase
  end

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;
  assign mepc_o        = {mepc_q, 2'b00};

  // The handler must start with interrupts masked, even if software wrote MIE
  a_trap_masks_mie : assert property (@(posedge clk) disable iff (!rst_ni)
    trap_req_i.take |=> !mstatus_mie_q)
    else $error("mstatus.mie still set after a taken trap");

endmodule

`default_nettype wire

/* hdl/trap_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module trap_ctrl (
  input  wire logic                              clk,
  input  wire logic                              rst_ni,
  input  wire trap_pkg::wb_pipe_t                wb_pipe_i,
  input  wire logic [trap_pkg::NUM_IRQ-1:0]      irq_i,
  input  wire logic [trap_pkg::NUM_IRQ-1:0]      mie_i,
  input  wire logic                              mstatus_mie_i,
  input  wire logic [trap_pkg::XLEN-1:0]         mepc_i,
  output trap_pkg::trap_req_t                    trap_req_o,
  output logic                                   mret_exec_o,
  output logic                                   pc_set_o,
  output logic [trap_pkg::XLEN-1:0]              pc_target_o,
  output logic                                   irq_ack_o,
  output logic [trap_pkg::IRQ_ID_W-1:0]          irq_id_o,
  output logic                                   commit_o
);

  trap_pkg::ctrl_state_e           state_q;
  trap_pkg::ctrl_state_e           state_d;
  logic [trap_pkg::NUM_IRQ-1:0]    irq_pending;
  logic [trap_pkg::IRQ_ID_W-1:0]   irq_sel;
  logic                            slot_live;
  logic                            irq_take;
  logic                            exc_take;
  logic                            mret_take;

  //////////////////////////////////////////////////////////////////////
  // Outcome selection for the slot in writeback
  //////////////////////////////////////////////////////////////////////

  // Only lines enabled in mie count as pending
  assign irq_pending = irq_i & mie_i;

  // Scan from the top so the lowest pending index is left in irq_sel
  always_comb begin
    irq_sel = '0;
    for (int i = trap_pkg::NUM_IRQ - 1; i >= 0; i--) begin
      if (irq_pending[i]) begin
        irq_sel = trap_pkg::IRQ_ID_W'(i);
      end
    end
  end

  // A slot behind a redirect is dead and neither traps nor commits
  assign slot_live = (state_q == trap_pkg::CTRL_RUN) && wb_pipe_i.valid;

  // Interrupts are taken on a valid slot and win over its exception
  assign irq_take  = slot_live && mstatus_mie_i && (|irq_pending);
  assign exc_take  = slot_live && !irq_take && (wb_pipe_i.exc_cause != trap_pkg::EXC_NONE);
  assign mret_take = slot_live && !irq_take && !exc_take && wb_pipe_i.mret;

  // An mret still retires and redirects as well
  assign commit_o    = slot_live && !irq_take && !exc_take;
  assign mret_exec_o = mret_take;
  assign pc_set_o    = irq_take || exc_take || mret_take;
  assign pc_target_o = mret_take ? mepc_i : trap_pkg::MTVEC_BASE;
  assign irq_ack_o   = irq_take;
  assign irq_id_o    = irq_sel;

  // The interrupt index doubles as the cause code in the command to the CSR bank
  always_comb begin
    trap_req_o.take   = irq_take || exc_take;
    trap_req_o.is_irq = irq_take;
    trap_req_o.cause  = irq_take ? 5'(irq_sel) : wb_pipe_i.exc_cause;
    trap_req_o.epc    = wb_pipe_i.pc;
  end

  //////////////////////////////////////////////////////////////////////
  // Run and flush FSM
  //////////////////////////////////////////////////////////////////////

  // Every redirect costs exactly one flushed slot
  assign state_d = pc_set_o ? trap_pkg::CTRL_FLUSH : trap_pkg::CTRL_RUN;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= trap_pkg::CTRL_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // The slot dropped in a flush cycle neither redirects nor commits
  a_quiet_flush : assert property (@(posedge clk) disable iff (!rst_ni)
    (state_q == trap_pkg::CTRL_FLUSH) |-> (!pc_set_o && !commit_o))
    else $error("pc_set_o or commit_o during a flush cycle");

  // The only commit that also redirects is an mret
  a_commit_redirect : assert property (@(posedge clk) disable iff (!rst_ni)
    (pc_set_o && commit_o) |-> mret_exec_o)
    else $error("pc_set_o together with a plain commit");

endmodule

`default_nettype wire

/* hdl/trap_pkg.sv */
`default_nettype none

package trap_pkg;

  //////////////////////////////////////////////////////////////////////
  // Machine parameters
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN     = 32;
  localparam int unsigned NUM_IRQ  = 16;
  localparam int unsigned IRQ_ID_W = $clog2(NUM_IRQ);

  // Traps always land on one fixed handler, since vectored mode is absent
  localparam logic [XLEN-1:0] MTVEC_BASE = 32'h0000_0100;

  // Only MIE and MPIE are implemented in mstatus
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam logic [XLEN-1:0] CSR_WRITABLE_MASK =
    (XLEN'(1) << MSTATUS_MIE_BIT) | (XLEN'(1) << MSTATUS_MPIE_BIT);

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Exception codes as written to mcause with the interrupt bit clear
  typedef enum logic [4:0] {
    EXC_NONE            = 5'd0,
    EXC_INSTR_FAULT     = 5'd1,
    EXC_ILLEGAL_INSN    = 5'd2,
    EXC_BREAKPOINT      = 5'd3,
    EXC_ECALL_MMODE     = 5'd11,
    EXC_INSTR_BUS_FAULT = 5'd24
  } exc_cause_e;

  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MIE     = 12'h304,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342
  } csr_addr_e;

  // FLUSH lasts one cycle and drops the slot behind a redirect
  typedef enum logic {
    CTRL_RUN   = 1'b0,
    CTRL_FLUSH = 1'b1
  } ctrl_state_e;

  //////////////////////////////////////////////////////////////////////
  // Structures passed between the blocks
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            illegal_insn;
    logic            ecall_insn;
    logic            ebrk_insn;
    logic            bus_err;
    logic            mpu_err;
    logic            mret_insn;
  } retire_t;

  // Fault flags are already reduced to one cause at this point
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    exc_cause_e      exc_cause;
    logic            mret;
  } wb_pipe_t;

  typedef struct packed {
    logic            take;
    logic            is_irq;
    logic [4:0]      cause;
    logic [XLEN-1:0] epc;
  } trap_req_t;

endpackage

`default_nettype wire

/* hdl/trap_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module trap_sva (
  input wire logic                          clk,
  input wire logic                          rst_ni,
  input wire trap_pkg::wb_pipe_t            wb_pipe_i,
  input wire trap_pkg::trap_req_t           trap_req_i,
  input wire logic [trap_pkg::NUM_IRQ-1:0]  mie_i,
  input wire logic                          mstatus_mie_i,
  input wire logic [trap_pkg::XLEN-1:0]     mepc_i,
  input wire logic                          irq_ack_i
);

  localparam int unsigned NUM_KIND = 5;

  // Exception kind tracked by each checker slot
  function automatic trap_pkg::exc_cause_e kind_cause(input int unsigned k);
    case (k)
      0:       return trap_pkg::EXC_INSTR_FAULT;
      1:       return trap_pkg::EXC_INSTR_BUS_FAULT;
      2:       return trap_pkg::EXC_ILLEGAL_INSN;
      3:       return trap_pkg::EXC_ECALL_MMODE;
      default: return trap_pkg::EXC_BREAKPOINT;
    endcase
  endfunction

  logic                       flush_q;
  logic                       slot_live;
  logic                       take_q;
  logic [4:0]                 take_cause_q;
  logic [NUM_KIND-1:0]        seen_q;
  logic [NUM_KIND-1:0]        written_q;
  logic [trap_pkg::XLEN-1:0]  exp_pc_q [NUM_KIND];
  logic [trap_pkg::XLEN-1:0]  act_pc_q [NUM_KIND];

  // Own view of the flush slot, rebuilt from the slot and the trap command
  assign slot_live = wb_pipe_i.valid && !flush_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_q      <= 1'b0;
      take_q       <= 1'b0;
      take_cause_q <= '0;
    end else begin
      flush_q      <= trap_req_i.take || (slot_live && wb_pipe_i.mret && !irq_ack_i);
      take_q       <= trap_req_i.take && !trap_req_i.is_irq;
      take_cause_q <= trap_req_i.cause;
    end
  end

  // Expected side records the first live slot of a kind, actual side reads
  // mepc the cycle after the matching exception was taken
  for (genvar k = 0; k < NUM_KIND; k++) begin : g_kind
    always_ff @(posedge clk or negedge rst_ni) begin
      if (!rst_ni) begin
        seen_q[k]    <= 1'b0;
        written_q[k] <= 1'b0;
        exp_pc_q[k]  <= '0;
        act_pc_q[k]  <= '0;
      end else begin
        if (!seen_q[k] && slot_live && !irq_ack_i &&
            (wb_pipe_i.exc_cause == kind_cause(k))) begin
          seen_q[k]   <= 1'b1;
          exp_pc_q[k] <= {wb_pipe_i.pc[trap_pkg::XLEN-1:2], 2'b00};
        end
        if (!written_q[k] && take_q && (take_cause_q == kind_cause(k))) begin
          written_q[k] <= 1'b1;
          act_pc_q[k]  <= mepc_i;
        end
      end
    end

    a_first_mepc : assert property (@(posedge clk) disable iff (!rst_ni)
      (seen_q[k] && written_q[k]) |=> (exp_pc_q[k] == act_pc_q[k]))
      else $error("mepc mismatch for cause %0d", kind_cause(k));
  end

  // An acknowledged interrupt must be enabled both globally and per line
  a_irq_enabled : assert property (@(posedge clk) disable iff (!rst_ni)
    irq_ack_i |-> (mstatus_mie_i && mie_i[trap_req_i.cause[trap_pkg::IRQ_ID_W-1:0]]))
    else $error("interrupt taken while disabled");

endmodule

`default_nettype wire

/* hdl/trap_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module trap_unit (
  input  wire logic                              clk,
  input  wire logic                              rst_ni,
  input  wire trap_pkg::retire_t                 retire_i,
  input  wire logic [trap_pkg::NUM_IRQ-1:0]      irq_i,
  input  wire logic                              csr_we_i,
  input  wire trap_pkg::csr_addr_e               csr_waddr_i,
  input  wire logic [trap_pkg::XLEN-1:0]         csr_wdata_i,
  input  wire trap_pkg::csr_addr_e               csr_raddr_i,
  output logic [trap_pkg::XLEN-1:0]              csr_rdata_o,
  output logic                                   pc_set_o,
  output logic [trap_pkg::XLEN-1:0]              pc_target_o,
  output logic                                   irq_ack_o,
  output logic [trap_pkg::IRQ_ID_W-1:0]          irq_id_o,
  output logic                                   commit_o
);

  trap_pkg::wb_pipe_t            wb_pipe;
  trap_pkg::trap_req_t           trap_req;
  logic                          mret_exec;
  logic [trap_pkg::NUM_IRQ-1:0]  mie_q;
  logic                          mstatus_mie_q;
  logic [trap_pkg::XLEN-1:0]     mepc_q;

  // Writeback slot feeding the controller
  trap_wb_stage u_wb_stage (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .retire_i  (retire_i),
    .wb_pipe_o (wb_pipe)
  );

  // Machine CSRs that keep trap state between events
  trap_csr_regs u_csr_regs (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .csr_we_i      (csr_we_i),
    .csr_waddr_i   (csr_waddr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_raddr_i   (csr_raddr_i),
    .trap_req_i    (trap_req),
    .mret_exec_i   (mret_exec),
    .csr_rdata_o   (csr_rdata_o),
    .mie_o         (mie_q),
    .mstatus_mie_o (mstatus_mie_q),
    .mepc_o        (mepc_q)
  );

  trap_ctrl u_ctrl (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .wb_pipe_i     (wb_pipe),
    .irq_i         (irq_i),
    .mie_i         (mie_q),
    .mstatus_mie_i (mstatus_mie_q),
    .mepc_i        (mepc_q),
    .trap_req_o    (trap_req),
    .mret_exec_o   (mret_exec),
    .pc_set_o      (pc_set_o),
    .pc_target_o   (pc_target_o),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o),
    .commit_o      (commit_o)
  );

  // Cross-module checks on mepc capture and interrupt enables
  trap_sva u_sva (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .wb_pipe_i     (wb_pipe),
    .trap_req_i    (trap_req),
    .mie_i         (mie_q),
    .mstatus_mie_i (mstatus_mie_q),
    .mepc_i        (mepc_q),
    .irq_ack_i     (irq_ack_o)
  );

endmodule

`default_nettype wire

/* hdl/trap_wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module trap_wb_stage (
  input  wire logic              clk,
  input  wire logic              rst_ni,
  input  wire trap_pkg::retire_t retire_i,
  output trap_pkg::wb_pipe_t     wb_pipe_o
);

  trap_pkg::exc_cause_e exc_cause;
  logic                 has_exc;

  // Priority encoder, highest priority is tested first
  // An MPU fault hides every later check since the instruction was never fetched
  always_comb begin
    if (retire_i.mpu_err) begin
      exc_cause = trap_pkg::EXC_INSTR_FAULT;
    end else if (retire_i.bus_err) begin
      exc_cause = trap_pkg::EXC_INSTR_BUS_FAULT;
    end else if (retire_i.illegal_insn) begin
      exc_cause = trap_pkg::EXC_ILLEGAL_INSN;
    end else if (retire_i.ecall_insn) begin
      exc_cause = trap_pkg::EXC_ECALL_MMODE;
    end else if (retire_i.ebrk_insn) begin
      exc_cause = trap_pkg::EXC_BREAKPOINT;
    end else begin
      exc_cause = trap_pkg::EXC_NONE;
    end
  end

  assign has_exc = (exc_cause != trap_pkg::EXC_NONE);

  // One slot, refilled every cycle since there is no back-pressure
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_pipe_o <= '0;
    end else begin
      wb_pipe_o.valid     <= retire_i.valid;
      wb_pipe_o.pc        <= retire_i.pc;
      wb_pipe_o.exc_cause <= exc_cause;
      // A faulting mret traps instead of returning
      wb_pipe_o.mret      <= retire_i.mret_insn && !has_exc;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_trap_model.svh */
`ifndef TB_TRAP_MODEL_SVH
`define TB_TRAP_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model state
//////////////////////////////////////////////////////////////////////

// Slot the model expects in writeback, and whether it sits behind a redirect
logic                           m_valid;
logic [trap_pkg::XLEN-1:0]      m_pc;
trap_pkg::exc_cause_e           m_cause;
logic                           m_mret;
logic                           m_flush;
// Machine CSRs as the model sees them after the last edge
logic                           m_mstatus_mie;
logic                           m_mstatus_mpie;
logic [trap_pkg::NUM_IRQ-1:0]   m_mie;
logic [trap_pkg::XLEN-1:0]      m_mepc;
logic                           m_mcause_irq;
logic [4:0]                     m_mcause_code;
logic [31:0]                    rng_state;

// Xorshift32 advances the state by one step per call
function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// Walk from the weakest flag to the strongest so the strongest one is kept
function automatic trap_pkg::exc_cause_e model_cause(input trap_pkg::retire_t r);
  trap_pkg::exc_cause_e c;
  c = trap_pkg::EXC_NONE;
  if (r.ebrk_insn)
    c = trap_pkg::EXC_BREAKPOINT;
  if (r.ecall_insn)
    c = trap_pkg::EXC_ECALL_MMODE;
  if (r.illegal_insn)
    c = trap_pkg::EXC_ILLEGAL_INSN;
  if (r.bus_err)
    c = trap_pkg::EXC_INSTR_BUS_FAULT;
  if (r.mpu_err)
    c = trap_pkg::EXC_INSTR_FAULT;
  return c;
endfunction

function automatic logic [trap_pkg::IRQ_ID_W-1:0] lowest_irq(
  input logic [trap_pkg::NUM_IRQ-1:0] pend
);
  logic [trap_pkg::IRQ_ID_W-1:0] id;
  logic                          found;
  id    = '0;
  found = 1'b0;
  for (int i = 0; i < trap_pkg::NUM_IRQ; i++) begin
    if (pend[i] && !found) begin
      id    = trap_pkg::IRQ_ID_W'(i);
      found = 1'b1;
    end
  end
  return id;
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_pc(input string name, input logic [trap_pkg::XLEN-1:0] exp,
                        input logic [trap_pkg::XLEN-1:0] got);
  if (got !== exp) begin
    $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, got);
    fail_stop();
  end
endtask

task automatic check_word(input string name, input logic [trap_pkg::XLEN-1:0] exp,
                          input logic [trap_pkg::XLEN-1:0] got);
  if (got !== exp) begin
    $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, got);
    fail_stop();
  end
endtask

task automatic check_irq_id(input string name, input logic [trap_pkg::IRQ_ID_W-1:0] exp,
                            input logic [trap_pkg::IRQ_ID_W-1:0] got);
  if (got !== exp) begin
    $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
    fail_stop();
  end
endtask

// mcause word is the interrupt bit on top and the code in the low five bits
task automatic check_cause(input string name, input logic exp_irq,
                           input trap_pkg::exc_cause_e exp_code,
                           input logic [trap_pkg::XLEN-1:0] got);
  logic [trap_pkg::XLEN-1:0] exp;
  exp                   = '0;
  exp[trap_pkg::XLEN-1] = exp_irq;
  exp[4:0]              = exp_code;
  if (got !== exp) begin
    $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, got);
    fail_stop();
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
  if (got !== exp) begin
    $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
    fail_stop();
  end
endtask

`endif

/* tb/tb_trap_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_trap_unit;

  localparam int unsigned NUM_CYCLES = 3000;
  localparam int unsigned CLK_PERIOD = 8;

  logic                           clk;
  logic                           rst_ni;
  trap_pkg::retire_t              retire;
  logic [trap_pkg::NUM_IRQ-1:0]   irq;
  logic                           csr_we;
  trap_pkg::csr_addr_e            csr_waddr;
  logic [trap_pkg::XLEN-1:0]      csr_wdata;
  trap_pkg::csr_addr_e            csr_raddr;
  logic [trap_pkg::XLEN-1:0]      csr_rdata;
  logic                           pc_set;
  logic [trap_pkg::XLEN-1:0]      pc_target;
  logic                           irq_ack;
  logic [trap_pkg::IRQ_ID_W-1:0]  irq_id;
  logic                           commit;
  int unsigned                    n_commit;
  int unsigned                    n_irq;
  int unsigned                    n_exc;
  int unsigned                    n_mret;

  task automatic fail_stop();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "tb_trap_model.svh"

  trap_unit u_trap_unit (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .retire_i    (retire),
    .irq_i       (irq),
    .csr_we_i    (csr_we),
    .csr_waddr_i (csr_waddr),
    .csr_wdata_i (csr_wdata),
    .csr_raddr_i (csr_raddr),
    .csr_rdata_o (csr_rdata),
    .pc_set_o    (pc_set),
    .pc_target_o (pc_target),
    .irq_ack_o   (irq_ack),
    .irq_id_o    (irq_id),
    .commit_o    (commit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // The margin of 100 cycles covers reset and the drain at the end
  initial begin
    #((NUM_CYCLES + 100) * CLK_PERIOD);
    $display("Watchdog expired, the test loop did not finish in time");
    fail_stop();
  end

  function automatic trap_pkg::csr_addr_e pick_csr(input logic [1:0] sel);
    case (sel)
      2'd0:    return trap_pkg::CSR_MSTATUS;
      2'd1:    return trap_pkg::CSR_MIE;
      2'd2:    return trap_pkg::CSR_MEPC;
      default: return trap_pkg::CSR_MCAUSE;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Random stimulus for one cycle
  //////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] lines;
    r                   = next_rand();
    retire              = '0;
    retire.valid        = (r % 10) < 7;
    r                   = next_rand();
    retire.pc           = {r[31:2], 2'b00};
    // Each fault flag fires about once in 32 retirements
    retire.mpu_err      = (next_rand() % 32) == 0;
    retire.bus_err      = (next_rand() % 32) == 0;
    retire.illegal_insn = (next_rand() % 32) == 0;
    retire.ecall_insn   = (next_rand() % 32) == 0;
    retire.ebrk_insn    = (next_rand() % 32) == 0;
    retire.mret_insn    = (next_rand() % 12) == 0;
    // Interrupt lines are sparse with each line set at 1/8 in one cycle of four
    r     = next_rand();
    lines = next_rand() & next_rand() & next_rand();
    irq   = (r[1:0] == 2'd0) ? lines[trap_pkg::NUM_IRQ-1:0] : '0;
    csr_we    = (r[3:2] == 2'd0);
    csr_waddr = pick_csr(r[5:4]);
    csr_wdata = next_rand();
    // Now and then the read port looks at an address that maps to nothing
    if (r[9:6] == 4'd0) begin
      csr_raddr = trap_pkg::csr_addr_e'(12'h7c0);
    end else begin
      csr_raddr = pick_csr(r[11:10]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Model step that checks this cycle and then predicts the next edge
  //////////////////////////////////////////////////////////////////////

  task automatic step_model();
    logic [trap_pkg::NUM_IRQ-1:0]  pend;
    logic [trap_pkg::IRQ_ID_W-1:0] irq_sel;
    logic [trap_pkg::XLEN-1:0]     mstatus_word;
    logic                          live;
    logic                          irq_take;
    logic                          exc_take;
    logic                          mret_take;
    logic                          trap;
    pend      = irq & m_mie;
    irq_sel   = lowest_irq(pend);
    live      = m_valid && !m_flush;
    irq_take  = live && m_mstatus_mie && (pend != '0);
    exc_take  = live && !irq_take && (m_cause != trap_pkg::EXC_NONE);
    mret_take = live && !irq_take && !exc_take && m_mret;
    trap      = irq_take || exc_take;

    check_bit("commit_o", live && !trap, commit);
    check_bit("pc_set_o", trap || mret_take, pc_set);
    check_bit("irq_ack_o", irq_take, irq_ack);
    if (irq_take) begin
      check_irq_id("irq_id_o", irq_sel, irq_id);
    end
    if (trap || mret_take) begin
      check_pc("pc_target_o", mret_take ? m_mepc : trap_pkg::MTVEC_BASE, pc_target);
    end

    // Readback reflects the CSRs as they stand after the last edge
    mstatus_word = '0;
    mstatus_word[trap_pkg::MSTATUS_MIE_BIT]  = m_mstatus_mie;
    mstatus_word[trap_pkg::MSTATUS_MPIE_BIT] = m_mstatus_mpie;
    case (csr_raddr)
      trap_pkg::CSR_MSTATUS: check_word("csr_rdata_o mstatus", mstatus_word, csr_rdata);
      trap_pkg::CSR_MIE:     check_word("csr_rdata_o mie", trap_pkg::XLEN'(m_mie), csr_rdata);
      trap_pkg::CSR_MEPC:    check_pc("csr_rdata_o mepc", m_mepc, csr_rdata);
      trap_pkg::CSR_MCAUSE:  check_cause("csr_rdata_o mcause", m_mcause_irq,
                                         trap_pkg::exc_cause_e'(m_mcause_code), csr_rdata);
      default:               check_word("csr_rdata_o unmapped", '0, csr_rdata);
    endcase

    n_commit += (live && !trap);
    n_irq    += irq_take;
    n_exc    += exc_take;
    n_mret   += mret_take;

    // A trap or mret on this edge beats a software write to the same CSR
    if (trap) begin
      m_mstatus_mpie = m_mstatus_mie;
      m_mstatus_mie  = 1'b0;
      m_mepc         = {m_pc[trap_pkg::XLEN-1:2], 2'b00};
      m_mcause_irq   = irq_take;
      m_mcause_code  = irq_take ? 5'(irq_sel) : 5'(m_cause);
    end else if (mret_take) begin
      m_mstatus_mie  = m_mstatus_mpie;
      m_mstatus_mpie = 1'b1;
    end
    if (csr_we && !trap && !mret_take && csr_waddr == trap_pkg::CSR_MSTATUS) begin
      m_mstatus_mie  = csr_wdata[trap_pkg::MSTATUS_MIE_BIT];
      m_mstatus_mpie = csr_wdata[trap_pkg::MSTATUS_MPIE_BIT];
    end
    if (csr_we && csr_waddr == trap_pkg::CSR_MIE) begin
      m_mie = csr_wdata[trap_pkg::NUM_IRQ-1:0];
    end
    if (csr_we && !trap && csr_waddr == trap_pkg::CSR_MEPC) begin
      m_mepc = {csr_wdata[trap_pkg::XLEN-1:2], 2'b00};
    end
    if (csr_we && !trap && csr_waddr == trap_pkg::CSR_MCAUSE) begin
      m_mcause_irq  = csr_wdata[trap_pkg::XLEN-1];
      m_mcause_code = csr_wdata[4:0];
    end

    // The retirement driven this cycle fills the slot on the coming edge
    m_valid = retire.valid;
    m_pc    = retire.pc;
    m_cause = model_cause(retire);
    m_mret  = retire.mret_insn && (m_cause == trap_pkg::EXC_NONE);
    m_flush = trap || mret_take;
  endtask

  initial begin
    rst_ni    = 1'b0;
    retire    = '0;
    irq       = '0;
    csr_we    = 1'b0;
    csr_waddr = trap_pkg::CSR_MSTATUS;
    csr_wdata = '0;
    csr_raddr = trap_pkg::CSR_MSTATUS;
    rng_state = 32'ha02ede1f;
    m_valid        = 1'b0;
    m_pc           = '0;
    m_cause        = trap_pkg::EXC_NONE;
    m_mret         = 1'b0;
    m_flush        = 1'b0;
    m_mstatus_mie  = 1'b0;
    m_mstatus_mpie = 1'b0;
    m_mie          = '0;
    m_mepc         = '0;
    m_mcause_irq   = 1'b0;
    m_mcause_code  = '0;
    n_commit = 0;
    n_irq    = 0;
    n_exc    = 0;
    n_mret   = 0;
    repeat (8) @(posedge clk);
    #1 rst_ni = 1'b1;

    // Inputs change 1 ns after the edge and outputs are checked 2 ns later
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(posedge clk);
      #1;
      drive_inputs();
      #2;
      step_model();
    end

    if (n_commit == 0 || n_irq == 0 || n_exc == 0 || n_mret == 0) begin
      $display("Some outcome never happened");
      $display("Commits %0d, interrupts %0d, exceptions %0d, mrets %0d",
               n_commit, n_irq, n_exc, n_mret);
      fail_stop();
    end else begin
      $display("Commits %0d, interrupts %0d, exceptions %0d, mrets %0d",
               n_commit, n_irq, n_exc, n_mret);
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* trap_unit.f */
+incdir+tb
hdl/trap_pkg.sv
hdl/trap_wb_stage.sv
hdl/trap_csr_regs.sv
hdl/trap_ctrl.sv
hdl/trap_sva.sv
hdl/trap_unit.sv
tb/tb_trap_unit.sv
